//--- conv_row_array.f
hdl/conv_pkg.sv
hdl/window_skewer.sv
hdl/conv_pe.sv
hdl/psum_collector.sv
hdl/conv_row_array.sv
test/conv_row_array_chk.sv
test/conv_row_array_tb.sv

//--- Bender.yml
package:
  name: conv_row_array

sources:
  # package first, then leaf modules, then the top level
  - hdl/conv_pkg.sv
  - hdl/window_skewer.sv
  - hdl/conv_pe.sv
  - hdl/psum_collector.sv
  - hdl/conv_row_array.sv
  - target: test
    files:
      - test/conv_row_array_chk.sv
      - test/conv_row_array_tb.sv

//--- test/conv_row_array_tb.sv
`timescale 1ns/1ps

module conv_row_array_tb;

  localparam int          clk_period     = 8;            // ns
  localparam int          reset_cycles   = 5;
  localparam int          frame_cols     = 16;           // columns in the basic frame
  localparam int          max_cols       = 32;           // pixel history depth
  localparam int          timeout_margin = 40;           // slack per test, covers the drain
  localparam logic [31:0] seed           = 32'h5d3bbd89;

  logic                   clk;
  logic                   rst_n;
  logic                   weight_we;
  conv_pkg::row_sel_t     weight_row;
  conv_pkg::row_weights_t weight_data;
  logic                   pixel_valid;
  logic [conv_pkg::num_rows*conv_pkg::pixel_w-1:0] pixel_col;
  logic                   frame_start;
  logic                   out_valid;
  conv_pkg::psum_t        out_data;

  int wgt [conv_pkg::num_rows][conv_pkg::num_taps]; // current filter, signed taps
  int pix [max_cols][conv_pkg::num_rows];           // pixels of the running frame
  int exp_q [$];                                    // expected results in order
  int cyc_q [$];                                    // cycle each result is due

  logic [31:0] rng_state = seed;
  int          cycle     = 0;
  int          deadline  = reset_cycles + timeout_margin;
  int          errors    = 0;
  int          checks    = 0;
  int          strobes   = 0;                       // out_valid pulses seen
  int          tests     = 0;
  int          failing   = 0;
  int          due;                                 // results expected this test
  int          errs_at_start;
  int          strobes_at_start;
  string       test_name = "reset";
  int          exp_val;
  int          exp_cyc;

  conv_row_array u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .weight_we   (weight_we),
    .weight_row  (weight_row),
    .weight_data (weight_data),
    .pixel_valid (pixel_valid),
    .pixel_col   (pixel_col),
    .frame_start (frame_start),
    .out_valid   (out_valid),
    .out_data    (out_data)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period/2) clk = ~clk;
  end

  // cycle count and watchdog
  always @(posedge clk) begin
    cycle = cycle + 1;
    if (cycle > deadline) begin
      $display("timeout in test %s at cycle %0d, results still missing", test_name, cycle);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // 3x3 dot product of the filter with columns j-2..j of the frame
  function automatic int ref_result(input int j);
    int acc;
    acc = 0;
    for (int k = 0; k < conv_pkg::num_rows; k++) begin
      for (int i = 0; i < conv_pkg::num_taps; i++) begin
        acc += wgt[k][i] * pix[j-i][k];   // tap i meets the pixel i columns back
      end
    end
    return acc;
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error: %s expected %08h got %08h at cycle %0d", name, exp, act, cycle);
    end
  endtask

  // compare process, sampled mid cycle where outputs are stable
  always @(negedge clk) begin
    if (rst_n && out_valid === 1'b1) begin
      strobes++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("out_valid at cycle %0d with no result pending", cycle);
      end else begin
        exp_val = exp_q.pop_front();
        exp_cyc = cyc_q.pop_front();
        check("out_data", exp_val, out_data);       // sign-extended to 32 bits
        check("out_valid cycle", exp_cyc, cycle);
      end
    end
  end

  task automatic tick();
    @(posedge clk);
    #1;                                 // drive point after the edge
  endtask

  task automatic arm_timeout(input int budget);
    deadline = cycle + budget + timeout_margin;
  endtask

  task automatic load_weights();
    for (int k = 0; k < conv_pkg::num_rows; k++) begin
      weight_we   = 1'b1;
      weight_row  = conv_pkg::row_sel_t'(k);
      weight_data = {8'(wgt[k][2]), 8'(wgt[k][1]), 8'(wgt[k][0])}; // tap 0 low
      tick();
    end
    weight_we = 1'b0;
  endtask

  task automatic random_weights();
    for (int k = 0; k < conv_pkg::num_rows; k++) begin
      for (int i = 0; i < conv_pkg::num_taps; i++) begin
        wgt[k][i] = int'($signed(next_rand()));   // wraps below
        wgt[k][i] = int'($signed(8'(wgt[k][i]))); // keep a signed byte
      end
    end
  endtask

  function automatic int pick_pixel(input bit extreme);
    logic [31:0] r;
    r = next_rand();
    if (extreme && r[1:0] == 2'd0) return 0;
    if (extreme && r[1:0] == 2'd1) return 255;
    return int'(r[15:8]);
  endfunction

  task automatic send_column(input int j, input bit first, input bit extreme);
    for (int k = 0; k < conv_pkg::num_rows; k++) begin
      pix[j][k] = pick_pixel(extreme);
      pixel_col[k*conv_pkg::pixel_w +: conv_pkg::pixel_w] = 8'(pix[j][k]);
    end
    pixel_valid = 1'b1;
    frame_start = first;
    if (j >= conv_pkg::num_taps - 1) begin
      exp_q.push_back(ref_result(j));
      cyc_q.push_back(cycle + 5);       // fixed pipeline latency
      due++;
    end
    tick();
    pixel_valid = 1'b0;
    frame_start = 1'b0;
  endtask

  task automatic send_frame(input int n_cols, input int max_gap, input bit extreme);
    int gap;
    for (int j = 0; j < n_cols; j++) begin
      send_column(j, j == 0, extreme);
      gap = (max_gap > 0) ? int'(next_rand() % (max_gap + 1)) : 0;
      repeat (gap) tick();              // windows hold between strobes
    end
  endtask

  task automatic begin_test(input string name, input int budget);
    test_name        = name;
    errs_at_start    = errors;
    strobes_at_start = strobes;
    due              = 0;
    arm_timeout(budget);
  endtask

  task automatic end_test();
    repeat (6) tick();                  // last result lands 5 cycles after its column
    if (exp_q.size() != 0) begin
      errors += exp_q.size();
      $display("%s ended with %0d results never published", test_name, exp_q.size());
      exp_q.delete();
      cyc_q.delete();
    end
    check("out_valid count", due, strobes - strobes_at_start);
    tests++;
    if (errors != errs_at_start) failing++;
    $display("test %0d %s: %s, %0d results, %0d errors", tests, test_name,
             (errors == errs_at_start) ? "ok" : "bad", due, errors - errs_at_start);
  endtask

  task automatic test_reset_then_frame();
    begin_test("reset_then_frame", 10 + conv_pkg::num_rows + frame_cols + 5);
    for (int n = 0; n < 10; n++) begin
      check("out_valid", 32'd0, {31'd0, out_valid}); // idle after reset
      tick();
    end
    random_weights();
    load_weights();
    send_frame(frame_cols, 0, 1'b0);    // back to back strobes
    end_test();
  endtask

  task automatic test_short_frames();
    begin_test("short_frames", 2 + 3 + 4 + 2 + 5 + 5);
    send_frame(2, 0, 1'b0);             // no result at all
    send_frame(3, 0, 1'b0);
    send_frame(4, 0, 1'b0);
    send_frame(2, 0, 1'b0);
    send_frame(5, 0, 1'b0);
    end_test();
  endtask

  task automatic test_random_gaps();
    begin_test("random_gaps", 20 * 5 + 5);
    send_frame(20, 4, 1'b0);
    end_test();
  endtask

  task automatic test_frame_restart();
    begin_test("frame_restart", 8 + 8 + 5);
    send_frame(8, 0, 1'b1);
    send_frame(8, 0, 1'b0);             // stale history must be flushed
    end_test();
  endtask

  task automatic test_weight_reload();
    begin_test("weight_reload", conv_pkg::num_rows + 12 + 5);
    wgt[0][0] = -128;
    wgt[0][1] = 127;
    wgt[0][2] = -1;
    wgt[1][0] = 127;
    wgt[1][1] = -128;
    wgt[1][2] = -128;
    wgt[2][0] = -1;
    wgt[2][1] = 0;
    wgt[2][2] = -128;
    load_weights();
    send_frame(12, 0, 1'b1);            // about half the pixels 0 or 255
    end_test();
  endtask

  initial begin
    rst_n       = 1'b0;
    weight_we   = 1'b0;
    weight_row  = '0;
    weight_data = '0;
    pixel_valid = 1'b0;
    pixel_col   = '0;
    frame_start = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst_n = 1'b1;

    test_reset_then_frame();
    test_short_frames();
    test_random_gaps();
    test_frame_restart();
    test_weight_reload();

    $display("summary: %0d tests, %0d failing, %0d checks, %0d errors",
             tests, failing, checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- test/conv_row_array_chk.sv
`timescale 1ns/1ps

module conv_row_array_chk (
  input logic            clk,
  input logic            rst_n,
  input logic            pixel_valid,
  input logic            out_valid,
  input conv_pkg::psum_t out_data
);

  // reset edge clears the strobe, checked from the second reset cycle on
  a_quiet_in_reset: assert property (@(posedge clk) (!rst_n ##1 !rst_n) |-> !out_valid)
    else $error("out_valid high while reset is held");

  // every result traces back to a column strobe, skewer + 3 pes + collector
  a_valid_has_column: assert property (
    @(posedge clk) disable iff (!rst_n) out_valid |-> $past(pixel_valid, 5))
    else $error("out_valid without a pixel_valid five cycles earlier");

  // a published result is fully driven
  a_data_known: assert property (
    @(posedge clk) disable iff (!rst_n) out_valid |-> !$isunknown(out_data))
    else $error("out_data unknown while out_valid is high");

endmodule

bind conv_row_array conv_row_array_chk u_chk (
  .clk         (clk),
  .rst_n       (rst_n),
  .pixel_valid (pixel_valid),
  .out_valid   (out_valid),
  .out_data    (out_data)
);

//--- hdl/conv_row_array.sv
`timescale 1ns/1ps

module conv_row_array (
  input  logic                   clk,
  input  logic                   rst_n,
  // filter load
  input  logic                   weight_we,    // one-cycle write strobe
  input  conv_pkg::row_sel_t     weight_row,   // target filter row
  input  conv_pkg::row_weights_t weight_data,  // three taps of that row
  // pixel columns
  input  logic                   pixel_valid,  // one column per strobe
  input  logic [conv_pkg::num_rows*conv_pkg::pixel_w-1:0] pixel_col, // row 0 low
  input  logic                   frame_start,  // with the first column
  // results, 5 cycles after the column
  output logic                   out_valid,
  output conv_pkg::psum_t        out_data
);

  logic [conv_pkg::num_rows-1:0] pe_en;                          // skewed enables
  conv_pkg::pixel_t              pe_pixel   [conv_pkg::num_rows]; // skewed pixels
  conv_pkg::row_weights_t        pe_weights [conv_pkg::num_rows]; // filter rows
  logic                          col_valid;                      // aligned with last pe
  logic                          col_first;

  // psum chain, entry k feeds pe k, last entry feeds the collector
  conv_pkg::psum_t psum_chain [conv_pkg::num_rows+1];

  assign psum_chain[0] = '0;                    // top of the chain starts at zero

  window_skewer u_skewer (
    .clk         (clk),
    .rst_n       (rst_n),
    .weight_we   (weight_we),
    .weight_row  (weight_row),
    .weight_data (weight_data),
    .pixel_valid (pixel_valid),
    .pixel_col   (pixel_col),
    .frame_start (frame_start),
    .pe_en       (pe_en),
    .pe_pixel    (pe_pixel),
    .pe_weights  (pe_weights),
    .col_valid   (col_valid),
    .col_first   (col_first)
  );

  // one pe per filter row, one cycle each
  for (genvar k = 0; k < conv_pkg::num_rows; k++) begin : g_pe
    conv_pe u_pe (
      .clk      (clk),
      .rst_n    (rst_n),
      .en       (pe_en[k]),
      .pixel    (pe_pixel[k]),
      .weights  (pe_weights[k]),
      .psum_in  (psum_chain[k]),
      .psum_out (psum_chain[k+1])           // into the next row's pe
    );
  end

  psum_collector u_collector (
    .clk       (clk),
    .rst_n     (rst_n),
    .col_valid (col_valid),
    .col_first (col_first),
    .psum_in   (psum_chain[conv_pkg::num_rows]), // full 3x3 sum
    .out_valid (out_valid),
    .out_data  (out_data)
  );

endmodule

//--- hdl/psum_collector.sv
`timescale 1ns/1ps

module psum_collector (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            col_valid,  // last pe has a new sum this cycle
  input  logic            col_first,  // that sum belongs to a frame's first column
  input  conv_pkg::psum_t psum_in,    // full 3x3 sum from the last pe
  output logic            out_valid,  // one-cycle result strobe
  output conv_pkg::psum_t out_data    // result, held until the next strobe
);

  conv_pkg::collect_state_t state_q;  // frame tracking
  conv_pkg::collect_state_t state_d;

  logic [1:0] col_cnt_q;              // index of the last column seen in filling
  logic [1:0] col_cnt_d;
  logic       emit;                   // this column produces a result

  // next state
  // a frame's first num_taps-1 columns only prime the windows
  always_comb begin
    state_d   = state_q;
    col_cnt_d = col_cnt_q;
    emit      = 1'b0;
    if (col_valid) begin
      if (col_first) begin
        state_d   = conv_pkg::filling; // restart from any state
        col_cnt_d = '0;                // this is column 0
      end else begin
        case (state_q)
          conv_pkg::idle: begin
            state_d = conv_pkg::idle;  // stray column before any frame
          end
          conv_pkg::filling: begin
            if (col_cnt_q == 2'(conv_pkg::num_taps - 2)) begin
              state_d = conv_pkg::streaming; // window now full of this frame
              emit    = 1'b1;                // column num_taps-1 is the first result
            end else begin
              col_cnt_d = col_cnt_q + 2'd1;
            end
          end
          conv_pkg::streaming: begin
            emit = 1'b1;               // every further column
          end
          default: begin
            state_d = conv_pkg::idle;  // unused encoding
          end
        endcase
      end
    end
  end

  // state and strobe
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q   <= conv_pkg::idle;
      col_cnt_q <= '0;
      out_valid <= 1'b0;
    end else begin
      state_q   <= state_d;
      col_cnt_q <= col_cnt_d;
      out_valid <= emit;             // pulse, no back-pressure
    end
  end

  // result register, loaded only with real results
  always_ff @(posedge clk) begin
    if (emit) begin
      out_data <= psum_in;
    end
  end

endmodule

//--- hdl/conv_pe.sv
`timescale 1ns/1ps

module conv_pe (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   en,       // new pixel for this row
  input  conv_pkg::pixel_t       pixel,    // newest pixel of the row
  input  conv_pkg::row_weights_t weights,  // filter row, tap 0 low
  input  conv_pkg::psum_t        psum_in,  // partial sum from the pe above
  output conv_pkg::psum_t        psum_out  // registered partial sum to the pe below
);

  // pixel history, entry 0 is the previous pixel
  conv_pkg::pixel_t hist_q [conv_pkg::num_taps-1];

  // window as seen on the current edge, tap i pairs with win[i]
  conv_pkg::pixel_t win [conv_pkg::num_taps];

  logic signed [conv_pkg::prod_w-1:0] prod [conv_pkg::num_taps]; // tap products
  conv_pkg::psum_t                    psum_d;                    // adder output

  // window assembly
  assign win[0] = pixel;                  // tap 0 takes the new pixel
  for (genvar i = 1; i < conv_pkg::num_taps; i++) begin : g_win
    assign win[i] = hist_q[i-1];          // older pixels for higher taps
  end

  // multipliers
  for (genvar i = 0; i < conv_pkg::num_taps; i++) begin : g_mul
    conv_pkg::weight_t tap;               // signed view of this tap

    assign tap = conv_pkg::weight_t'(weights[i*conv_pkg::weight_w +: conv_pkg::weight_w]);

    // pixel is zero-extended so the multiply stays signed
    assign prod[i] = $signed({1'b0, win[i]}) * tap;
  end

  // partial sum adder, products sign-extend to psum width
  always_comb begin
    psum_d = psum_in;
    for (int i = 0; i < conv_pkg::num_taps; i++) begin
      psum_d = psum_d + conv_pkg::psum_t'(prod[i]);
    end
  end

  // window shift, advances only on en
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < conv_pkg::num_taps-1; i++) begin
        hist_q[i] <= '0;                  // empty window
      end
    end else if (en) begin
      hist_q[0] <= pixel;                 // newest becomes previous
      for (int i = 1; i < conv_pkg::num_taps-1; i++) begin
        hist_q[i] <= hist_q[i-1];         // older ones move back
      end
    end
  end

  // output register, held between strobes
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      psum_out <= '0;
    end else if (en) begin
      psum_out <= psum_d;                 // same edge as the window shift
    end
  end

endmodule

//--- hdl/window_skewer.sv
`timescale 1ns/1ps

module window_skewer (
  input  logic                                       clk,
  input  logic                                       rst_n,
  // filter load port
  input  logic                                       weight_we,   // one-cycle write strobe
  input  conv_pkg::row_sel_t                         weight_row,  // which filter row
  input  conv_pkg::row_weights_t                     weight_data, // three taps, tap 0 low
  // pixel column port
  input  logic                                       pixel_valid, // one-cycle column strobe
  input  logic [conv_pkg::num_rows*conv_pkg::pixel_w-1:0] pixel_col, // row 0 in low byte
  input  logic                                       frame_start, // first column of a frame
  // per-row pe feeds
  output logic [conv_pkg::num_rows-1:0]              pe_en,       // row k delayed k+1
  output conv_pkg::pixel_t                           pe_pixel   [conv_pkg::num_rows],
  output conv_pkg::row_weights_t                     pe_weights [conv_pkg::num_rows],
  // flags for the collector, aligned with the last pe output
  output logic                                       col_valid,
  output logic                                       col_first
);

  conv_pkg::row_weights_t wgt_q [conv_pkg::num_rows]; // filter row registers

  logic [conv_pkg::num_rows:0] vld_sr;    // column valid delay, num_rows+1 stages
  logic [conv_pkg::num_rows:0] first_sr;  // frame start delay, same depth

  // filter rows, written one at a time
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int r = 0; r < conv_pkg::num_rows; r++) begin
        wgt_q[r] <= '0;                   // zero taps until loaded
      end
    end else if (weight_we && (int'(weight_row) < conv_pkg::num_rows)) begin
      wgt_q[weight_row] <= weight_data;   // out of range rows dropped
    end
  end

  // triangular delay line
  // row k sees its pixel k+1 cycles late, so each psum arrives
  // at pe k exactly when that pe gets its own pixel of the same column
  for (genvar k = 0; k < conv_pkg::num_rows; k++) begin : g_row
    logic [k:0]       en_sr;              // enable stages for this row
    conv_pkg::pixel_t pix_sr [k+1];       // pixel stages

    always_ff @(posedge clk) begin
      if (!rst_n) begin
        en_sr <= '0;                      // no pe fires after reset
      end else begin
        en_sr[0] <= pixel_valid;          // stage 0 from the input strobe
        for (int s = 1; s <= k; s++) begin
          en_sr[s] <= en_sr[s-1];         // ripple down the row
        end
      end
    end

    always_ff @(posedge clk) begin
      pix_sr[0] <= pixel_col[k*conv_pkg::pixel_w +: conv_pkg::pixel_w]; // this row's byte
      for (int s = 1; s <= k; s++) begin
        pix_sr[s] <= pix_sr[s-1];         // follows the enable stage by stage
      end
    end

    assign pe_en[k]      = en_sr[k];      // last stage drives the pe
    assign pe_pixel[k]   = pix_sr[k];
    assign pe_weights[k] = wgt_q[k];      // filter row k goes to pe k
  end

  // flag delay line
  // one stage per pe plus the skewer stage itself
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_sr   <= '0;
      first_sr <= '0;
    end else begin
      vld_sr   <= {vld_sr[conv_pkg::num_rows-1:0], pixel_valid};
      first_sr <= {first_sr[conv_pkg::num_rows-1:0], pixel_valid & frame_start}; // qualified
    end
  end

  assign col_valid = vld_sr[conv_pkg::num_rows];   // same cycle as last pe's new sum
  assign col_first = first_sr[conv_pkg::num_rows];

endmodule

//--- hdl/conv_pkg.sv
package conv_pkg;

  // array geometry
  localparam int num_rows = 3;             // kernel height, one pe per row
  localparam int num_taps = 3;             // kernel width, window length per pe

  // data widths
  localparam int pixel_w  = 8;             // unsigned image sample
  localparam int weight_w = 8;             // signed filter tap
  localparam int psum_w   = 20;            // nine 17-bit products fit here
  localparam int prod_w   = pixel_w + weight_w + 1; // zero-extended pixel times tap

  // index of a filter row on the weight write port
  localparam int row_sel_w = 2;

  typedef logic [pixel_w-1:0] pixel_t;     // one pixel, unsigned

  typedef logic signed [weight_w-1:0] weight_t; // one tap, two's complement

  // one filter row, tap 0 in the low byte
  typedef logic [num_taps*weight_w-1:0] row_weights_t;

  typedef logic signed [psum_w-1:0] psum_t; // partial sum or final result

  typedef logic [row_sel_w-1:0] row_sel_t; // filter row select

  // collector frame tracking
  typedef enum logic [1:0] {
    idle,                                  // no frame seen yet
    filling,                               // first columns of a frame, windows not full
    streaming                              // every column yields a result
  } collect_state_t;

endpackage
